// File: verilog/icache_cfg_pkg.sv
package icache_cfg_pkg;

    //////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////

    // 4 ways of 64 sets
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 64;
    localparam int WAY_W    = 2;

    // one line holds eight instructions
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    // address split, tag | index | byte offset
    localparam int TAG_W    = 21;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 5;

endpackage

// File: verilog/icache_types_pkg.sv
package icache_types_pkg;

    // fetch address as seen by the cache
    typedef struct packed {
        logic [icache_cfg_pkg::TAG_W-1:0]    tag;
        logic [icache_cfg_pkg::INDEX_W-1:0]  index;
        logic [icache_cfg_pkg::OFFSET_W-1:0] offset;
    } fetch_addr_t;

    typedef struct packed {
        logic [icache_cfg_pkg::TAG_W-1:0] tag;
    } tag_entry_t;

    // words[0] sits in the low 32 bits of the memory beat
    typedef struct packed {
        logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][icache_cfg_pkg::WORD_W-1:0] words;
    } cache_line_t;

    typedef struct packed {
        logic        valid;
        fetch_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic                              ok1;
        logic                              ok2;
        fetch_addr_t                       pc;
        logic [icache_cfg_pkg::WORD_W-1:0] inst1;
        logic [icache_cfg_pkg::WORD_W-1:0] inst2;
    } fetch_resp_t;

    typedef struct packed {
        logic [icache_cfg_pkg::NUM_WAYS-1:0] we;
        logic [icache_cfg_pkg::INDEX_W-1:0]  index;
        tag_entry_t                          tag;
    } fill_wr_t;

endpackage

// File: verilog/cache_ram.sv
module cache_ram #(
    parameter type payload_t = logic
) (
    input  logic                               clk,
    input  logic                               we_i,
    input  logic [icache_cfg_pkg::INDEX_W-1:0] wr_index_i,
    input  payload_t                           wr_data_i,
    input  logic                               rd_en_i,
    input  logic [icache_cfg_pkg::INDEX_W-1:0] rd_index_i,
    output payload_t                           rd_data_o
);

    payload_t mem [icache_cfg_pkg::NUM_SETS];

    // write port, one entry per set
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_index_i] <= wr_data_i;
        end
    end

    // registered read, held when not enabled
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_index_i];
        end
    end

endmodule

// File: verilog/fetch_req_stage.sv
module fetch_req_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 valid_i,
    input  icache_types_pkg::fetch_addr_t        addr_i,
    input  logic                                 stall_i,
    input  logic                                 done_i,
    output logic                                 rd_en_o,
    output logic [icache_cfg_pkg::INDEX_W-1:0]   rd_index_o,
    output icache_types_pkg::fetch_req_t         req_o
);

    logic                          accept;
    logic                          req_valid_q;
    icache_types_pkg::fetch_addr_t req_addr_q;

    assign accept = valid_i && !stall_i;

    // arrays only read on accept, output holds during a miss
    assign rd_en_o    = accept;
    assign rd_index_o = addr_i.index;

    always_ff @(posedge clk) begin
        if (!rst) begin
            req_valid_q <= 1'b0;
        end else if (!stall_i) begin
            req_valid_q <= valid_i;
        end else if (done_i) begin
            // miss served in this cycle, drop it
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= addr_i;
        end
    end

    assign req_o = '{valid: req_valid_q, addr: req_addr_q};

endmodule

// File: verilog/hit_select.sv
module hit_select (
    input  logic                               clk,
    input  logic                               rst,
    input  icache_types_pkg::fetch_req_t       req_i,
    input  icache_types_pkg::tag_entry_t       tags_i [icache_cfg_pkg::NUM_WAYS],
    input  icache_types_pkg::cache_line_t      lines_i [icache_cfg_pkg::NUM_WAYS],
    input  icache_types_pkg::fill_wr_t         fill_i,
    output logic                               hit_o,
    output logic [icache_cfg_pkg::WAY_W-1:0]   hit_way_o,
    output icache_types_pkg::cache_line_t      hit_line_o
);

    logic [icache_cfg_pkg::NUM_SETS-1:0][icache_cfg_pkg::NUM_WAYS-1:0] valid_q;
    logic [icache_cfg_pkg::NUM_WAYS-1:0]                               way_hit;

    // valid bits, set when a way is refilled
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                if (fill_i.we[w]) begin
                    valid_q[fill_i.index][w] <= 1'b1;
                end
            end
        end
    end

    // per-way tag compare
    for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : g_cmp
        assign way_hit[w] = valid_q[req_i.addr.index][w] &&
                            (tags_i[w].tag == req_i.addr.tag);
    end

    assign hit_o = req_i.valid && (|way_hit);

    // at most one way matches, so no priority is needed
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way_o = w[icache_cfg_pkg::WAY_W-1:0];
            end
        end
    end

    assign hit_line_o = lines_i[hit_way_o];

endmodule

// File: verilog/plru_tree.sv
module plru_tree (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [icache_cfg_pkg::INDEX_W-1:0] index_i,
    input  logic                               touch_i,
    input  logic [icache_cfg_pkg::WAY_W-1:0]   touch_way_i,
    output logic [icache_cfg_pkg::WAY_W-1:0]   victim_way_o
);

    // tree bits per set
    logic [icache_cfg_pkg::NUM_SETS-1:0] root_q;
    logic [icache_cfg_pkg::NUM_SETS-1:0] leaf1_q;
    logic [icache_cfg_pkg::NUM_SETS-1:0] leaf2_q;

    //////////////////////////////////////////////////
    // victim choice
    //////////////////////////////////////////////////

    // root picks the pair, the leaf picks inside it
    always_comb begin
        if (root_q[index_i]) begin
            victim_way_o = {1'b1, leaf2_q[index_i]};
        end else begin
            victim_way_o = {1'b0, leaf1_q[index_i]};
        end
    end

    //////////////////////////////////////////////////
    // update on use
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            root_q  <= '0;
            leaf1_q <= '0;
            leaf2_q <= '0;
        end else if (touch_i) begin
            // point away from the way just used
            root_q[index_i] <= ~touch_way_i[1];
            if (!touch_way_i[1]) begin
                leaf1_q[index_i] <= ~touch_way_i[0];
            end else begin
                leaf2_q[index_i] <= ~touch_way_i[0];
            end
        end
    end

endmodule

// File: verilog/refill_ctrl.sv
module refill_ctrl (
    input  icache_types_pkg::fetch_req_t       req_i,
    input  logic                               hit_i,
    input  logic [icache_cfg_pkg::WAY_W-1:0]   hit_way_i,
    input  icache_types_pkg::cache_line_t      hit_line_i,
    input  logic [icache_cfg_pkg::WAY_W-1:0]   victim_way_i,
    input  logic                               ret_valid_i,
    input  icache_types_pkg::cache_line_t      ret_data_i,
    output logic                               stall_o,
    output logic                               rd_req_o,
    output icache_types_pkg::fetch_addr_t      rd_addr_o,
    output icache_types_pkg::fill_wr_t         fill_o,
    output logic                               touch_o,
    output logic [icache_cfg_pkg::WAY_W-1:0]   touch_way_o,
    output icache_types_pkg::fetch_resp_t      resp_o
);

    logic                                miss;
    logic                                refill;
    logic                                last_word;
    logic [2:0]                          word_off;
    icache_types_pkg::cache_line_t       src_line;

    //////////////////////////////////////////////////
    // miss handling
    //////////////////////////////////////////////////

    assign miss   = req_i.valid && !hit_i;
    assign refill = miss && ret_valid_i;

    // stall covers the return cycle as well
    assign stall_o   = miss;
    assign rd_req_o  = miss && !ret_valid_i;
    assign rd_addr_o = '{tag: req_i.addr.tag, index: req_i.addr.index, offset: '0};

    assign fill_o.we    = refill ? (icache_cfg_pkg::NUM_WAYS'(1) << victim_way_i) : '0;
    assign fill_o.index = req_i.addr.index;
    assign fill_o.tag   = '{tag: req_i.addr.tag};

    //////////////////////////////////////////////////
    // response words
    //////////////////////////////////////////////////

    assign word_off  = req_i.addr.offset[icache_cfg_pkg::OFFSET_W-1:2];
    assign last_word = &word_off;
    assign src_line  = hit_i ? hit_line_i : ret_data_i;

    assign resp_o.ok1   = hit_i || refill;
    assign resp_o.ok2   = resp_o.ok1 && !last_word;
    assign resp_o.pc    = req_i.addr;
    assign resp_o.inst1 = src_line.words[word_off];
    // second word never crosses into the next line
    assign resp_o.inst2 = last_word ? '0 : src_line.words[word_off + 3'd1];

    // replacement state follows every served fetch
    assign touch_o     = resp_o.ok1;
    assign touch_way_o = hit_i ? hit_way_i : victim_way_i;

endmodule

// File: verilog/icache_top.sv
module icache_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           valid_i,
    input  icache_types_pkg::fetch_addr_t  addr_i,
    output logic                           stall_o,
    output icache_types_pkg::fetch_resp_t  resp_o,
    output logic                           rd_req_o,
    output icache_types_pkg::fetch_addr_t  rd_addr_o,
    input  logic                           ret_valid_i,
    input  icache_types_pkg::cache_line_t  ret_data_i
);

    icache_types_pkg::fetch_req_t       req;
    logic                               rd_en;
    logic [icache_cfg_pkg::INDEX_W-1:0] rd_index;
    icache_types_pkg::tag_entry_t       way_tags [icache_cfg_pkg::NUM_WAYS];
    icache_types_pkg::cache_line_t      way_lines [icache_cfg_pkg::NUM_WAYS];
    logic                               hit;
    logic [icache_cfg_pkg::WAY_W-1:0]   hit_way;
    icache_types_pkg::cache_line_t      hit_line;
    logic [icache_cfg_pkg::WAY_W-1:0]   victim_way;
    icache_types_pkg::fill_wr_t         fill;
    logic                               touch;
    logic [icache_cfg_pkg::WAY_W-1:0]   touch_way;

    // stage one, request capture and array read
    fetch_req_stage u_req (
        .clk(clk), .rst(rst),
        .valid_i(valid_i), .addr_i(addr_i),
        .stall_i(stall_o), .done_i(resp_o.ok1),
        .rd_en_o(rd_en), .rd_index_o(rd_index), .req_o(req)
    );

    //////////////////////////////////////////////////
    // per-way tag and line arrays
    //////////////////////////////////////////////////

    for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : g_way
        cache_ram #(.payload_t(icache_types_pkg::tag_entry_t)) u_tag_ram (
            .clk(clk), .we_i(fill.we[w]), .wr_index_i(fill.index), .wr_data_i(fill.tag),
            .rd_en_i(rd_en), .rd_index_i(rd_index), .rd_data_o(way_tags[w])
        );
        cache_ram #(.payload_t(icache_types_pkg::cache_line_t)) u_line_ram (
            .clk(clk), .we_i(fill.we[w]), .wr_index_i(fill.index), .wr_data_i(ret_data_i),
            .rd_en_i(rd_en), .rd_index_i(rd_index), .rd_data_o(way_lines[w])
        );
    end

    // stage two, lookup
    hit_select u_hit (
        .clk(clk), .rst(rst), .req_i(req),
        .tags_i(way_tags), .lines_i(way_lines), .fill_i(fill),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line)
    );

    plru_tree u_plru (
        .clk(clk), .rst(rst), .index_i(req.addr.index),
        .touch_i(touch), .touch_way_i(touch_way), .victim_way_o(victim_way)
    );

    refill_ctrl u_refill (
        .req_i(req), .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .victim_way_i(victim_way), .ret_valid_i(ret_valid_i), .ret_data_i(ret_data_i),
        .stall_o(stall_o), .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .fill_o(fill), .touch_o(touch), .touch_way_o(touch_way), .resp_o(resp_o)
    );

endmodule

// File: verif/icache_properties.sv
module icache_properties (
    input logic                          clk,
    input logic                          rst,
    input logic                          stall_o,
    input icache_types_pkg::fetch_resp_t resp_o,
    input logic                          rd_req_o,
    input icache_types_pkg::fetch_addr_t rd_addr_o,
    input logic                          ret_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // line address held until the refill beat
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        rd_req_o && !ret_valid_i |=> $stable(rd_addr_o))
        else $error("rd_addr_o changed during a pending memory request");

    a_ok2_ok1: assert property (@(posedge clk) disable iff (!rst) resp_o.ok2 |-> resp_o.ok1)
        else $error("ok2 high without ok1");

    // a line fetch always holds the requester
    a_req_stall: assert property (@(posedge clk) disable iff (!rst) rd_req_o |-> stall_o)
        else $error("rd_req_o high while stall_o is low");

    a_reset_quiet: assert property (@(posedge clk)
        !rst |=> !(stall_o || rd_req_o || resp_o.ok1 || resp_o.ok2))
        else $error("output active in the cycle after reset");

endmodule

bind icache_top icache_properties u_props (
    .clk(clk), .rst(rst), .stall_o(stall_o), .resp_o(resp_o),
    .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o), .ret_valid_i(ret_valid_i)
);

// File: verif/icache_tb.sv
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        icache_types_pkg::fetch_addr_t addr;
        logic                          hit;
        logic [31:0]                   cycle;
    } pend_t;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          valid_i;
    icache_types_pkg::fetch_addr_t addr_i;
    logic                          stall_o;
    icache_types_pkg::fetch_resp_t resp_o;
    logic                          rd_req_o;
    icache_types_pkg::fetch_addr_t rd_addr_o;
    logic                          ret_valid_i = 1'b0;
    icache_types_pkg::cache_line_t ret_data_i = '0;

    integer      seed = 32'ha32fda7a;
    int          mem_wait = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          err_mark = 0;
    logic [31:0] cycle = '0;
    logic        saw_req = 1'b0;
    string       test_name = "reset";
    pend_t       pend_q[$];

    // model of tags, valid bits and tree bits
    logic [icache_cfg_pkg::TAG_W-1:0] m_tag [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];
    logic [icache_cfg_pkg::NUM_SETS-1:0][icache_cfg_pkg::NUM_WAYS-1:0] m_valid = '0;
    logic [icache_cfg_pkg::NUM_SETS-1:0] m_root = '0;
    logic [icache_cfg_pkg::NUM_SETS-1:0] m_leaf1 = '0;
    logic [icache_cfg_pkg::NUM_SETS-1:0] m_leaf2 = '0;

    icache_top dut0 (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////

    // memory contents as a fixed scramble of the byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic icache_types_pkg::cache_line_t line_data(
        input icache_types_pkg::fetch_addr_t a
    );
        icache_types_pkg::cache_line_t l;
        for (int i = 0; i < 8; i++) begin
            l.words[i] = mem_word({a.tag, a.index, 3'(i), 2'b00});
        end
        return l;
    endfunction

    function automatic icache_types_pkg::fetch_resp_t expect_resp(
        input icache_types_pkg::fetch_addr_t a
    );
        icache_types_pkg::fetch_resp_t r;
        logic [2:0]                    w;
        w       = a.offset[4:2];
        r.ok1   = 1'b1;
        r.ok2   = (w != 3'd7);
        r.pc    = a;
        r.inst1 = mem_word({a.tag, a.index, w, 2'b00});
        r.inst2 = r.ok2 ? mem_word({a.tag, a.index, w + 3'd1, 2'b00}) : '0;
        return r;
    endfunction

    // predicts hit or miss and updates the model as the cache would
    function automatic logic model_lookup(input icache_types_pkg::fetch_addr_t a);
        logic hit;
        int   way;
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
            if (m_valid[a.index][w] && m_tag[a.index][w] == a.tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit && m_root[a.index]) begin
            way = m_leaf2[a.index] ? 3 : 2;
        end else if (!hit) begin
            way = m_leaf1[a.index] ? 1 : 0;
        end
        if (!hit) begin
            m_valid[a.index][way] = 1'b1;
            m_tag[a.index][way]   = a.tag;
        end
        // tree points away from the way just used
        m_root[a.index] = (way < 2);
        if (way < 2) begin
            m_leaf1[a.index] = (way == 0);
        end else begin
            m_leaf2[a.index] = (way == 2);
        end
        return hit;
    endfunction

    function automatic icache_types_pkg::fetch_addr_t mk_addr(
        input logic [20:0] tag, input logic [5:0] index, input logic [2:0] word
    );
        return '{tag: tag, index: index, offset: {word, 2'b00}};
    endfunction

    //////////////////////////////////////////////////
    // checks and stimulus
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic check_resp(input icache_types_pkg::fetch_resp_t exp,
                              input icache_types_pkg::fetch_resp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_addr(input icache_types_pkg::fetch_addr_t exp,
                              input icache_types_pkg::fetch_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_flag(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", test_name, exp, act);
        end
    endtask

    task automatic issue(input icache_types_pkg::fetch_addr_t a);
        int n = 0;
        @(negedge clk);
        valid_i = 1'b1;
        addr_i  = a;
        do begin
            @(posedge clk);
            n++;
        end while (stall_o && n < 50);
        if (stall_o) begin
            report_failure($sformatf("fetch %h was never accepted", a));
        end
    endtask

    task automatic drain();
        int n = 0;
        @(negedge clk);
        valid_i = 1'b0;
        while (pend_q.size() != 0 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (pend_q.size() != 0) begin
            report_failure($sformatf("timed out with %0d fetches unanswered", pend_q.size()));
            pend_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == err_mark) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    // memory answers a line request after 1 to 4 cycles
    always @(negedge clk) begin
        if (ret_valid_i) begin
            ret_valid_i = 1'b0;
        end else if (mem_wait > 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                ret_data_i  = line_data(rd_addr_o);
                ret_valid_i = 1'b1;
            end
        end else if (rd_req_o) begin
            mem_wait = 1 + ({$random(seed)} % 4);
        end
    end

    // compare process samples outputs as they stand before each edge
    always @(posedge clk) begin
        pend_t head;
        if (rst) begin
            cycle = cycle + 32'd1;
            // stall holds while a miss sits in stage two, up to its refill cycle
            check_flag(pend_q.size() != 0 && !pend_q[0].hit, stall_o);
            if (rd_req_o && pend_q.size() == 0) begin
                report_failure("memory request with no fetch outstanding");
            end else if (rd_req_o && pend_q[0].hit) begin
                report_failure("memory request for a fetch that should hit");
            end else if (rd_req_o && !saw_req) begin
                saw_req          = 1'b1;
                head             = pend_q[0];
                head.addr.offset = '0;
                check_addr(head.addr, rd_addr_o);
            end
            if (resp_o.ok1 && pend_q.size() == 0) begin
                report_failure("response with no fetch outstanding");
            end else if (resp_o.ok1) begin
                head = pend_q.pop_front();
                if (head.hit && cycle != head.cycle + 32'd1) begin
                    report_failure("hit was not answered one cycle after acceptance");
                end
                if (!head.hit && !saw_req) begin
                    report_failure("miss was answered without a memory request");
                end
                saw_req = 1'b0;
                check_resp(expect_resp(head.addr), resp_o);
            end
            if (valid_i && !stall_o) begin
                head.addr  = addr_i;
                head.hit   = model_lookup(addr_i);
                head.cycle = cycle;
                pend_q.push_back(head);
            end
        end
    end

    initial begin
        rst     = 1'b0;
        valid_i = 1'b0;
        addr_i  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        start_test("reset");
        @(negedge clk);
        check_flag(1'b0, stall_o);
        check_flag(1'b0, rd_req_o);
        check_flag(1'b0, resp_o.ok1);
        end_test();

        start_test("cold_miss");
        issue(mk_addr(21'h0a5c3, 6'h11, 3'd2));
        drain();
        end_test();

        start_test("hit_after_fill");
        for (int w = 2; w < 6; w++) begin
            issue(mk_addr(21'h0a5c3, 6'h11, 3'(w)));
        end
        drain();
        end_test();

        start_test("last_word");
        issue(mk_addr(21'h0a5c3, 6'h11, 3'd7));
        issue(mk_addr(21'h13579, 6'h2e, 3'd7));
        issue(mk_addr(21'h13579, 6'h2e, 3'd0));
        issue(mk_addr(21'h13579, 6'h2e, 3'd6));
        drain();
        end_test();

        // four tags fill set 7, the first is touched again, then a fifth evicts
        start_test("replacement");
        for (int k = 0; k < 4; k++) begin
            issue(mk_addr(21'h00100 + 21'(k), 6'h07, 3'(k)));
        end
        issue(mk_addr(21'h00100, 6'h07, 3'd5));
        issue(mk_addr(21'h00104, 6'h07, 3'd1));
        for (int k = 0; k < 4; k++) begin
            issue(mk_addr(21'h00100 + 21'(k), 6'h07, 3'd3));
        end
        drain();
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: icache.f
verilog/icache_cfg_pkg.sv
verilog/icache_types_pkg.sv
verilog/cache_ram.sv
verilog/fetch_req_stage.sv
verilog/hit_select.sv
verilog/plru_tree.sv
verilog/refill_ctrl.sv
verilog/icache_top.sv
verif/icache_properties.sv
verif/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f icache.f --top-module icache_tb -Mdir obj_dir

out="$(./obj_dir/Vicache_tb)"
echo "$out"
echo "$out" | grep -qx "=== PASS ==="
